/* common/ldpc_enc_pkg.sv */
// encoder sizes, parity shift table, sink bank states, word rotate function
`default_nettype none

package ldpc_enc_pkg;

  // ----------------------------------------------------------
  // block geometry
  // ----------------------------------------------------------

  // info words per block
  localparam int INFO_NUM = 4;

  // parity lanes the table can feed
  localparam int PAR_MAX = 4;

  // longest codeword, sizes the sink bank address
  localparam int WORD_NUM_MAX = INFO_NUM + PAR_MAX;

  // widest word the rotate function handles
  localparam int WORD_W_MAX = 32;

  // ----------------------------------------------------------
  // base shift table
  // ----------------------------------------------------------

  // row j = parity word j, column i = info word i
  // -1 means info word i is not part of parity j
  localparam int shift_tab [PAR_MAX][INFO_NUM] = '{
    '{ 0,  1,  3, -1},
    '{ 2, -1,  0,  5},
    '{-1,  4,  7,  1},
    '{ 6,  2, -1,  3}
  };

  // ----------------------------------------------------------
  // sink bank states
  // ----------------------------------------------------------

  typedef enum logic [1:0] {
    bank_empty = 2'd0,
    bank_full  = 2'd1,
    bank_send  = 2'd2
  } bank_state_e;

  // rotate left over the low width bits, shift taken mod width
  // callers drop negative table entries before calling
  function automatic logic [WORD_W_MAX-1:0] rot_word(input logic [WORD_W_MAX-1:0] w,
                                                     input int sh,
                                                     input int width);
    logic [WORD_W_MAX-1:0] r;
    int                    s;
    r = '0;
    s = sh % width;
    // bit k lands on bit k+s, wrapping at width
    for (int k = 0; k < WORD_W_MAX; k++) begin
      if (k < width) begin
        r[(k + s) % width] = w[k];
      end
    end
    return r;
  endfunction

endpackage

`default_nettype wire

/* enc/ldpc_parity_lane.sv */
// parity lane that xors the rotated info words of one table row
`timescale 1ns/10ps
`default_nettype none

module ldpc_parity_lane
  import ldpc_enc_pkg::*;
#(
  parameter int data_w = 8,
  parameter int row    = 0
) (
  input  wire                          iclk,
  input  wire                          rst_n,
  // broadcast from the source
  input  wire                          acc_en,
  input  wire                          acc_first,
  input  wire [$clog2(INFO_NUM)-1:0]   acc_idx,
  input  wire [data_w-1:0]             acc_data,
  // running parity of this row
  output logic [data_w-1:0]            par_word
);

  // table entry for the word on the bus
  int                    shift;
  logic [WORD_W_MAX-1:0] rot_full;
  logic [data_w-1:0]     contrib;

  // ----------------------------------------------------------
  // table lookup and rotate
  // ----------------------------------------------------------

  always_comb begin
    shift    = shift_tab[row][acc_idx];
    rot_full = rot_word(WORD_W_MAX'(acc_data), (shift < 0) ? 0 : shift, data_w);
    // -1 entry contributes nothing
    if (shift < 0) begin
      contrib = '0;
    end else begin
      contrib = rot_full[data_w-1:0];
    end
  end

  // ----------------------------------------------------------
  // accumulator
  // ----------------------------------------------------------

  // final right after the eop edge and held until the next first word
  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      par_word <= '0;
    end else if (acc_en) begin
      if (acc_first) begin
        // first word loads so nothing of the old block is left
        par_word <= contrib;
      end else begin
        par_word <= par_word ^ contrib;
      end
    end
  end

endmodule

`default_nettype wire

/* enc/ldpc_enc_source.sv */
// input handshake, word index, framing check, lane and sink feed
`timescale 1ns/10ps
`default_nettype none

module ldpc_enc_source
  import ldpc_enc_pkg::*;
#(
  parameter int data_w = 8,
  parameter int tag_w  = 4
) (
  input  wire                          iclk,
  input  wire                          rst_n,
  // input stream
  input  wire                          in_valid,
  output logic                         in_ready,
  input  wire                          in_sop,
  input  wire                          in_eop,
  input  wire [data_w-1:0]             in_data,
  input  wire [tag_w-1:0]              in_tag,
  output logic                         src_err,
  // broadcast to parity lanes
  output logic                         acc_en,
  output logic                         acc_first,
  output logic [$clog2(INFO_NUM)-1:0]  acc_idx,
  output logic [data_w-1:0]            acc_data,
  // systematic words to sink
  output logic                         wr_en,
  output logic [$clog2(INFO_NUM)-1:0]  wr_idx,
  output logic [data_w-1:0]            wr_data,
  output logic [tag_w-1:0]             wr_tag,
  output logic                         commit,
  input  wire                          bank_free
);

  localparam int idx_w = $clog2(INFO_NUM);

  // block in progress, next expected index
  logic             active;
  logic [idx_w-1:0] cnt;
  // index of the word on the bus right now
  logic [idx_w-1:0] cur_idx;
  // tag captured with sop
  logic [tag_w-1:0] tag_r;
  logic             accept;
  logic             in_block;
  logic             is_last;

  // ----------------------------------------------------------
  // handshake and index
  // ----------------------------------------------------------

  // only accept while the sink has a free bank to load
  assign in_ready = bank_free;
  assign accept   = in_valid & in_ready;

  // sop always restarts at index 0
  assign in_block = in_sop | active;
  assign cur_idx  = in_sop ? '0 : cnt;
  assign is_last  = (cur_idx == idx_w'(INFO_NUM - 1));

  // words outside a block are taken and ignored
  assign acc_en    = accept & in_block;
  assign acc_first = acc_en & (cur_idx == '0);
  assign acc_idx   = cur_idx;
  assign acc_data  = in_data;

  // same word, same cycle, into the loading bank
  assign wr_en   = acc_en;
  assign wr_idx  = cur_idx;
  assign wr_data = in_data;
  assign wr_tag  = in_sop ? in_tag : tag_r;

  // ----------------------------------------------------------
  // framing check
  // ----------------------------------------------------------

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      active  <= 1'b0;
      cnt     <= '0;
      src_err <= 1'b0;
      commit  <= 1'b0;
    end else begin
      // both are single cycle pulses
      src_err <= 1'b0;
      commit  <= 1'b0;
      if (acc_en) begin
        if (in_eop && is_last) begin
          // good block goes to the sink
          commit <= 1'b1;
          active <= 1'b0;
          cnt    <= '0;
        end else if (in_eop || is_last) begin
          // early or missing eop drops the block
          src_err <= 1'b1;
          active  <= 1'b0;
          cnt     <= '0;
        end else begin
          active <= 1'b1;
          cnt    <= cur_idx + 1'b1;
        end
      end
    end
  end

  // tag of the current block
  always_ff @(posedge iclk) begin
    if (acc_en && in_sop) begin
      tag_r <= in_tag;
    end
  end

endmodule

`default_nettype wire

/* enc/ldpc_enc_sink.sv */
// two codeword banks, bank states, output stream serializer
`timescale 1ns/10ps
`default_nettype none

module ldpc_enc_sink
  import ldpc_enc_pkg::*;
#(
  parameter int data_w  = 8,
  parameter int tag_w   = 4,
  parameter int par_num = 2
) (
  input  wire                          iclk,
  input  wire                          rst_n,
  // systematic words from the source
  input  wire                          wr_en,
  input  wire [$clog2(INFO_NUM)-1:0]   wr_idx,
  input  wire [data_w-1:0]             wr_data,
  input  wire [tag_w-1:0]              wr_tag,
  input  wire                          commit,
  // lane p sits at bits p*data_w
  input  wire [par_num*data_w-1:0]     par_bus,
  output logic                         bank_free,
  // output stream
  output logic                         out_valid,
  input  wire                          out_ready,
  output logic                         out_sop,
  output logic                         out_eop,
  output logic [data_w-1:0]            out_data,
  output logic [tag_w-1:0]             out_tag
);

  // codeword length and bank address width
  localparam int cw_num = INFO_NUM + par_num;
  localparam int aw     = $clog2(WORD_NUM_MAX);

  // ----------------------------------------------------------
  // storage and state
  // ----------------------------------------------------------

  logic [data_w-1:0] mem     [2][WORD_NUM_MAX];
  logic [tag_w-1:0]  tag_mem [2];
  bank_state_e       bank_st [2];

  // bank being loaded, bank to send next
  logic              ld_ptr;
  logic              sd_ptr;
  // write target is already the next bank in the commit cycle
  logic              ld_bank;
  logic [aw-1:0]     rd_cnt;
  logic [aw-1:0]     rd_addr;
  logic              sending;
  logic              start;
  logic              out_fire;
  logic              load_word;

  // a new block may start while the old one commits
  assign ld_bank   = ld_ptr ^ commit;
  assign bank_free = (bank_st[ld_bank] == bank_empty);

  // one bank on the output at a time
  assign sending   = (bank_st[0] == bank_send) | (bank_st[1] == bank_send);
  assign start     = (bank_st[sd_ptr] == bank_full) & ~sending;
  assign out_fire  = out_valid & out_ready;

  // next word into the output register
  assign load_word = start | (out_fire & ~out_eop);
  assign rd_addr   = start ? '0 : rd_cnt;

  // ----------------------------------------------------------
  // bank write
  // ----------------------------------------------------------

  always_ff @(posedge iclk) begin
    if (wr_en) begin
      mem[ld_bank][aw'(wr_idx)] <= wr_data;
      tag_mem[ld_bank]          <= wr_tag;
    end
    // parity goes behind the info words at commit
    if (commit) begin
      for (int p = 0; p < par_num; p++) begin
        mem[ld_ptr][aw'(INFO_NUM + p)] <= par_bus[p*data_w +: data_w];
      end
    end
  end

  // ----------------------------------------------------------
  // bank states and pointers
  // ----------------------------------------------------------

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      bank_st[0] <= bank_empty;
      bank_st[1] <= bank_empty;
      ld_ptr     <= 1'b0;
      sd_ptr     <= 1'b0;
    end else begin
      // loaded bank turns full and the load pointer moves on
      if (commit) begin
        bank_st[ld_ptr] <= bank_full;
        ld_ptr          <= ~ld_ptr;
      end
      if (start) begin
        bank_st[sd_ptr] <= bank_send;
      end
      // bank is free again once its last word is gone
      if (out_fire && out_eop) begin
        bank_st[sd_ptr] <= bank_empty;
        sd_ptr          <= ~sd_ptr;
      end
    end
  end

  // ----------------------------------------------------------
  // output serializer
  // ----------------------------------------------------------

  // markers hold while out_ready is low
  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_sop   <= 1'b0;
      out_eop   <= 1'b0;
      rd_cnt    <= '0;
    end else if (start) begin
      out_valid <= 1'b1;
      out_sop   <= 1'b1;
      out_eop   <= 1'b0;
      rd_cnt    <= aw'(1);
    end else if (out_fire) begin
      out_sop <= 1'b0;
      if (out_eop) begin
        out_valid <= 1'b0;
        out_eop   <= 1'b0;
      end else begin
        out_eop <= (rd_cnt == aw'(cw_num - 1));
        rd_cnt  <= rd_cnt + 1'b1;
      end
    end
  end

  // data and tag follow the same load
  always_ff @(posedge iclk) begin
    if (load_word) begin
      out_data <= mem[sd_ptr][rd_addr];
      out_tag  <= tag_mem[sd_ptr];
    end
  end

endmodule

`default_nettype wire

/* src/ldpc_enc_top.sv */
// encoder top level with the source, the parity lane array and the sink
`timescale 1ns/10ps
`default_nettype none

module ldpc_enc_top
  import ldpc_enc_pkg::*;
#(
  parameter int data_w  = 8,
  parameter int tag_w   = 4,
  parameter int par_num = 2
) (
  input  wire                iclk,
  input  wire                rst_n,
  // input stream
  input  wire                in_valid,
  output logic               in_ready,
  input  wire                in_sop,
  input  wire                in_eop,
  input  wire [data_w-1:0]   in_data,
  input  wire [tag_w-1:0]    in_tag,
  output logic               src_err,
  // output stream
  output logic               out_valid,
  input  wire                out_ready,
  output logic               out_sop,
  output logic               out_eop,
  output logic [data_w-1:0]  out_data,
  output logic [tag_w-1:0]   out_tag
);

  // ----------------------------------------------------------
  // internal nets
  // ----------------------------------------------------------

  // source to lanes
  logic                         acc_en;
  logic                         acc_first;
  logic [$clog2(INFO_NUM)-1:0]  acc_idx;
  logic [data_w-1:0]            acc_data;
  // source to sink
  logic                         wr_en;
  logic [$clog2(INFO_NUM)-1:0]  wr_idx;
  logic [data_w-1:0]            wr_data;
  logic [tag_w-1:0]             wr_tag;
  logic                         commit;
  logic                         bank_free;
  // lanes to sink
  logic [par_num*data_w-1:0]    par_bus;

  ldpc_enc_source #(
    .data_w (data_w),
    .tag_w  (tag_w)
  ) u_source (
    .iclk      (iclk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_sop    (in_sop),
    .in_eop    (in_eop),
    .in_data   (in_data),
    .in_tag    (in_tag),
    .src_err   (src_err),
    .acc_en    (acc_en),
    .acc_first (acc_first),
    .acc_idx   (acc_idx),
    .acc_data  (acc_data),
    .wr_en     (wr_en),
    .wr_idx    (wr_idx),
    .wr_data   (wr_data),
    .wr_tag    (wr_tag),
    .commit    (commit),
    .bank_free (bank_free)
  );

  // one lane per parity word
  for (genvar g = 0; g < par_num; g++) begin : g_lane
    ldpc_parity_lane #(
      .data_w (data_w),
      .row    (g)
    ) u_lane (
      .iclk      (iclk),
      .rst_n     (rst_n),
      .acc_en    (acc_en),
      .acc_first (acc_first),
      .acc_idx   (acc_idx),
      .acc_data  (acc_data),
      .par_word  (par_bus[g*data_w +: data_w])
    );
  end

  ldpc_enc_sink #(
    .data_w  (data_w),
    .tag_w   (tag_w),
    .par_num (par_num)
  ) u_sink (
    .iclk      (iclk),
    .rst_n     (rst_n),
    .wr_en     (wr_en),
    .wr_idx    (wr_idx),
    .wr_data   (wr_data),
    .wr_tag    (wr_tag),
    .commit    (commit),
    .par_bus   (par_bus),
    .bank_free (bank_free),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_sop   (out_sop),
    .out_eop   (out_eop),
    .out_data  (out_data),
    .out_tag   (out_tag)
  );

endmodule

`default_nettype wire

/* verif/tb_clkgen.sv */
// testbench clock and active low reset generator
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
  parameter int period     = 8,
  parameter int rst_cycles = 10
) (
  output logic iclk,
  output logic rst_n
);

  // free running clock, low at time 0
  initial begin
    iclk = 1'b0;
    forever #(period / 2) iclk = ~iclk;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (rst_cycles) @(posedge iclk);
    @(negedge iclk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* verif/ldpc_enc_sva.sv */
// bound checks on the encoder top: output hold, reset values, bank occupancy
`timescale 1ns/10ps
`default_nettype none

module ldpc_enc_sva #(
  parameter int data_w = 8,
  parameter int tag_w  = 4
) (
  input wire              iclk,
  input wire              rst_n,
  input wire              in_ready,
  input wire              src_err,
  input wire              commit,
  input wire              out_valid,
  input wire              out_ready,
  input wire              out_sop,
  input wire              out_eop,
  input wire [data_w-1:0] out_data,
  input wire [tag_w-1:0]  out_tag
);

  // committed codewords whose last word has not left yet
  int unsent;
  // number of failed assertions
  int fail_cnt = 0;

  always_ff @(posedge iclk or negedge rst_n) begin
    if (!rst_n) begin
      unsent <= 0;
    end else begin
      unsent <= unsent + (commit ? 1 : 0) - ((out_valid && out_ready && out_eop) ? 1 : 0);
    end
  end

  // ----------------------------------------------------------
  // output stream
  // ----------------------------------------------------------

  // back-pressure holds the word and its markers
  hold_under_stall: assert property (@(posedge iclk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_sop)
      && $stable(out_eop) && $stable(out_tag))
  else begin
    $error("output word changed while out_ready was low");
    fail_cnt++;
  end

  // nothing leaves the encoder while in reset
  quiet_in_reset: assert property (@(posedge iclk)
    !rst_n |-> !out_valid && !commit && !src_err)
  else begin
    $error("output, commit or error pulse active during reset");
    fail_cnt++;
  end

  // ----------------------------------------------------------
  // bank occupancy
  // ----------------------------------------------------------

  // at most two codewords fit in the sink
  two_banks_max: assert property (@(posedge iclk) disable iff (!rst_n)
    unsent <= 2)
  else begin
    $error("more than two codewords waiting in the sink");
    fail_cnt++;
  end

  // the block in its commit cycle already owns a bank
  ready_needs_bank: assert property (@(posedge iclk) disable iff (!rst_n)
    in_ready |-> unsent + (commit ? 1 : 0) < 2)
  else begin
    $error("in_ready high with both banks taken");
    fail_cnt++;
  end

endmodule

bind ldpc_enc_top ldpc_enc_sva #(
  .data_w (data_w),
  .tag_w  (tag_w)
) u_sva (
  .iclk      (iclk),
  .rst_n     (rst_n),
  .in_ready  (in_ready),
  .src_err   (src_err),
  .commit    (commit),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_sop   (out_sop),
  .out_eop   (out_eop),
  .out_data  (out_data),
  .out_tag   (out_tag)
);

`default_nettype wire

/* verif/ldpc_enc_tb.sv */
// testbench top: stimulus, reference model, output checks, timeout
`timescale 1ns/10ps
`default_nettype none

module ldpc_enc_tb
  import ldpc_enc_pkg::*;
();

  localparam int data_w  = 8;
  localparam int tag_w   = 4;
  localparam int par_num = 2;
  // expected entry is {tag, sop, eop, data}
  localparam int ent_w   = tag_w + 2 + data_w;
  // blocks sent over all tests, and how many of them are good
  localparam int blocks_total = 16;
  localparam int good_total   = 13;
  localparam int cyc_limit    = 20 * blocks_total + 200;

  logic              iclk;
  logic              rst_n;
  logic              in_valid;
  logic              in_ready;
  logic              in_sop;
  logic              in_eop;
  logic [data_w-1:0] in_data;
  logic [tag_w-1:0]  in_tag;
  logic              src_err;
  logic              out_valid;
  logic              out_ready;
  logic              out_sop;
  logic              out_eop;
  logic [data_w-1:0] out_data;
  logic [tag_w-1:0]  out_tag;

  integer            seed;
  int                mis_cnt  = 0;
  int                oth_cnt  = 0;
  int                sva_cnt  = 0;
  int                cyc_cnt  = 0;
  int                cw_out   = 0;
  // 0 ready high, 1 ready low, 2 random
  int                rdy_mode = 0;
  logic [ent_w-1:0]  exp_q [$];
  logic [ent_w-1:0]  ent;

  // reference model state
  logic              m_active = 1'b0;
  int                m_idx    = 0;
  logic [tag_w-1:0]  m_tag;
  logic [data_w-1:0] m_words [INFO_NUM];
  logic              err_due  = 1'b0;
  // latency watch after an eop into an idle encoder
  logic              lat_on   = 1'b0;
  int                lat_n    = 0;

  tb_clkgen #(.period(8), .rst_cycles(10)) u_clk (.iclk(iclk), .rst_n(rst_n));

  ldpc_enc_top dut (
    .iclk      (iclk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_sop    (in_sop),
    .in_eop    (in_eop),
    .in_data   (in_data),
    .in_tag    (in_tag),
    .src_err   (src_err),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_sop   (out_sop),
    .out_eop   (out_eop),
    .out_data  (out_data),
    .out_tag   (out_tag)
  );

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------

  function automatic logic [data_w-1:0] rotate_left(input logic [data_w-1:0] w, input int s);
    int r;
    r = s % data_w;
    if (r == 0) begin
      return w;
    end
    return (w << r) | (w >> (data_w - r));
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic check_value(input string name, input int exp_v, input int got_v);
    assert (got_v == exp_v) else begin
      $display("MISMATCH t=%0t %s exp=%0h got=%0h", $time, name, exp_v, got_v);
      mis_cnt++;
    end
  endtask

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------

  // info words as sent, then parity rows from the shift table
  task automatic push_codeword();
    logic [data_w-1:0] par;
    for (int i = 0; i < INFO_NUM; i++) begin
      exp_q.push_back({m_tag, (i == 0), 1'b0, m_words[i]});
    end
    for (int j = 0; j < par_num; j++) begin
      par = '0;
      for (int i = 0; i < INFO_NUM; i++) begin
        // -1 entries skip the word
        if (shift_tab[j][i] >= 0) begin
          par ^= rotate_left(m_words[i], shift_tab[j][i]);
        end
      end
      exp_q.push_back({m_tag, 1'b0, (j == par_num - 1), par});
    end
  endtask

  // one accepted input word
  task automatic model_accept();
    if (in_sop) begin
      m_active = 1'b1;
      m_idx    = 0;
      m_tag    = in_tag;
    end
    if (m_active) begin
      m_words[m_idx] = in_data;
      if (in_eop && m_idx == INFO_NUM - 1) begin
        // nothing pending, so the fixed latency applies
        if (exp_q.size() == 0) begin
          lat_on = 1'b1;
          lat_n  = 0;
        end
        push_codeword();
        m_active = 1'b0;
      end else if (in_eop || m_idx == INFO_NUM - 1) begin
        err_due  = 1'b1;
        m_active = 1'b0;
      end else begin
        m_idx++;
      end
    end
  endtask

  // ----------------------------------------------------------
  // monitor sampled on the rising edge
  // ----------------------------------------------------------

  always @(posedge iclk) begin
    if (rst_n) begin
      // out_valid low for two samples, then high with sop
      if (lat_on) begin
        lat_n++;
        if (lat_n < 3) begin
          check_value("out_valid", 0, int'(out_valid));
        end else begin
          check_value("out_valid", 1, int'(out_valid));
          check_value("out_sop", 1, int'(out_sop));
          lat_on = 1'b0;
        end
      end
      // error pulse one cycle after the bad word
      check_value("src_err", int'(err_due), int'(src_err));
      err_due = 1'b0;
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("unexpected output word at %0t with no codeword pending", $time);
          oth_cnt++;
        end else begin
          ent = exp_q.pop_front();
          check_value("out_data", int'(ent[data_w-1:0]), int'(out_data));
          check_value("out_eop", int'(ent[data_w]), int'(out_eop));
          check_value("out_sop", int'(ent[data_w+1]), int'(out_sop));
          check_value("out_tag", int'(ent[ent_w-1 -: tag_w]), int'(out_tag));
        end
        if (out_eop) begin
          cw_out++;
        end
      end
      if (in_valid && in_ready) begin
        model_accept();
      end
    end
  end

  always @(posedge iclk) begin
    cyc_cnt++;
    if (cyc_cnt == cyc_limit) begin
      $display("timeout: run did not finish within %0d cycles", cyc_limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // out_ready pattern changes on the falling edge
  initial begin
    out_ready = 1'b1;
    forever begin
      @(negedge iclk);
      if (rdy_mode == 2) begin
        out_ready = 1'($random(seed));
      end else begin
        out_ready = (rdy_mode == 0);
      end
    end
  end

  // ----------------------------------------------------------
  // stimulus tasks start and end on a falling edge
  // ----------------------------------------------------------

  task automatic send_word(input logic sop, input logic eop, input logic [data_w-1:0] d,
                           input logic [tag_w-1:0] t, input int gap);
    logic took;
    in_valid = 1'b1;
    in_sop   = sop;
    in_eop   = eop;
    in_data  = d;
    in_tag   = t;
    took     = 1'b0;
    while (!took) begin
      @(posedge iclk);
      took = in_ready;
      @(negedge iclk);
    end
    in_valid = 1'b0;
    in_sop   = 1'b0;
    in_eop   = 1'b0;
    repeat (gap) @(negedge iclk);
  endtask

  // eop_at of -1 leaves the block without an eop
  task automatic send_block(input int eop_at, input int n_words, input int max_gap);
    logic [tag_w-1:0] t;
    t = tag_w'($random(seed));
    for (int i = 0; i < n_words; i++) begin
      send_word((i == 0), (i == eop_at), data_w'($random(seed)), t, rand_below(max_gap + 1));
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge iclk);
    repeat (2) @(negedge iclk);
  endtask

  // mode is read on the falling edge, so set it on the rising one
  task automatic set_ready_mode(input int m);
    @(posedge iclk);
    rdy_mode = m;
    @(negedge iclk);
  endtask

  initial begin
    seed     = 32'hecfd_2e5f;
    in_valid = 1'b0;
    in_sop   = 1'b0;
    in_eop   = 1'b0;
    in_data  = '0;
    in_tag   = '0;
    wait (rst_n);
    @(negedge iclk);

    // single block into an idle encoder
    send_block(3, 4, 0);
    wait_drain();

    // back to back blocks with idle gaps
    repeat (4) send_block(3, 4, 3);
    wait_drain();

    // both banks filled under a stalled output
    set_ready_mode(1);
    repeat (2) send_block(3, 4, 0);
    fork
      send_block(3, 4, 0);
      begin
        repeat (15) @(negedge iclk);
        assert (!in_ready) else begin
          $display("in_ready stayed high at %0t with both banks occupied", $time);
          oth_cnt++;
        end
        set_ready_mode(2);
      end
    join
    repeat (3) send_block(3, 4, 2);
    wait_drain();
    set_ready_mode(0);

    // early eop, missing eop, a stray word, then a good block
    send_block(1, 2, 1);
    send_block(-1, 4, 1);
    send_word(1'b0, 1'b0, data_w'($random(seed)), '0, 1);
    send_block(3, 4, 1);
    wait_drain();

    // sop in the middle restarts the block
    send_block(-1, 2, 0);
    send_block(3, 4, 0);
    wait_drain();

    check_value("codeword_count", good_total, cw_out);
    sva_cnt = dut.u_sva.fail_cnt;
    $display("errors: mismatch=%0d other=%0d assertion=%0d", mis_cnt, oth_cnt, sva_cnt);
    if (mis_cnt + oth_cnt + sva_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
common/ldpc_enc_pkg.sv
enc/ldpc_parity_lane.sv
enc/ldpc_enc_source.sv
enc/ldpc_enc_sink.sv
src/ldpc_enc_top.sv
verif/tb_clkgen.sv
verif/ldpc_enc_sva.sv
verif/ldpc_enc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the LDPC encoder testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert \
  -f sim.f \
  --top-module ldpc_enc_tb \
  -o ldpc_enc_sim

# keep running past assertion errors so the testbench reports them
./obj_dir/ldpc_enc_sim +verilator+error+limit+100 | tee "$log"

if grep -q "TESTBENCH PASSED" "$log"; then
  echo "run_sim: simulation passed"
  exit 0
else
  echo "run_sim: simulation failed, see $log"
  exit 1
fi
